// File: source/bp_pkg.sv
package bp_pkg;

    // fetch and ex PCs are word addresses
    localparam int addr_width = 30;

    // table geometry, one entry per index value
    localparam int index_width = 8;
    localparam int table_depth = 1 << index_width;

    // global history, folded straight into the gshare index
    localparam int ghr_width = 8;

    localparam int ctr_width = 2;

    // branch kind codes as decoded by the core
    localparam int kind_width = 3;
    localparam logic [kind_width-1:0] kind_not_jump      = 3'd0;
    localparam logic [kind_width-1:0] kind_direct_jump   = 3'd1;
    localparam logic [kind_width-1:0] kind_jump          = 3'd2;
    localparam logic [kind_width-1:0] kind_call          = 3'd3;
    localparam logic [kind_width-1:0] kind_ret           = 3'd4;
    localparam logic [kind_width-1:0] kind_indirect_jump = 3'd5;
    localparam logic [kind_width-1:0] kind_other_jump    = 3'd6;

    // direction counters come out of reset leaning not taken
    localparam logic [ctr_width-1:0] ctr_weak_not_taken = 2'b01;

    // chooser counters come out of reset leaning bimodal, 2 or more picks gshare
    localparam logic [ctr_width-1:0] ctr_weak_bimodal = 2'b01;

    // saturation bounds shared by every counter
    localparam logic [ctr_width-1:0] ctr_min = 2'b00;
    localparam logic [ctr_width-1:0] ctr_max = 2'b11;

endpackage

// File: source/index_hash.sv
`timescale 1ns/1ps

module index_hash import bp_pkg::*; (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic [addr_width-1:0]  fetch_pc,
    input  logic [addr_width-1:0]  ex_pc,
    input  logic [ghr_width-1:0]   ex_ghr,
    input  logic                   ghr_shift_en,
    input  logic                   ghr_shift_bit,
    output logic [ghr_width-1:0]   pred_ghr,
    output logic [index_width-1:0] fetch_bimodal_index,
    output logic [index_width-1:0] fetch_gshare_index,
    output logic [index_width-1:0] ex_bimodal_index,
    output logic [index_width-1:0] ex_gshare_index
);

    // non-speculative history, only resolved conditional branches land here
    logic [ghr_width-1:0] ghr;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ghr <= '0;
        end else if (ghr_shift_en) begin
            ghr <= {ghr[ghr_width-2:0], ghr_shift_bit};
        end
    end

    assign pred_ghr = ghr;

    // fetch side uses the live history
    assign fetch_bimodal_index = fetch_pc[index_width-1:0];
    assign fetch_gshare_index  = fetch_pc[index_width-1:0] ^ ghr;

    // resolve side uses the history the prediction saw,
    // so training lands on the entry read at fetch
    assign ex_bimodal_index = ex_pc[index_width-1:0];
    assign ex_gshare_index  = ex_pc[index_width-1:0] ^ ex_ghr;

    a_shift_bit_known: assert property (
        @(posedge clk) disable iff (!arst_n)
        ghr_shift_en |-> !$isunknown(ghr_shift_bit)
    ) else $error("history shift with unknown outcome bit");

endmodule

// File: source/pattern_table.sv
`timescale 1ns/1ps

module pattern_table import bp_pkg::*; (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic [index_width-1:0] read_index,
    input  logic [index_width-1:0] train_index,
    input  logic                   train_en,
    input  logic                   train_taken,
    output logic                   pred_taken
);

    logic [ctr_width-1:0] ctr_q [table_depth];
    logic [ctr_width-1:0] ctr_old;
    logic [ctr_width-1:0] ctr_new;

    // read-modify-write, one step toward the outcome
    always_comb begin
        ctr_old = ctr_q[train_index];
        ctr_new = ctr_old;
        if (train_taken) begin
            if (ctr_old != ctr_max) begin
                ctr_new = ctr_old + 2'd1;
            end
        end else begin
            if (ctr_old != ctr_min) begin
                ctr_new = ctr_old - 2'd1;
            end
        end
    end

    // whole table comes back weakly not taken
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < table_depth; i++) begin
                ctr_q[i] <= ctr_weak_not_taken;
            end
        end else if (train_en) begin
            ctr_q[train_index] <= ctr_new;
        end
    end

    // upper bit is the direction
    // a same-cycle write is not seen until after the edge
    assign pred_taken = ctr_q[read_index][ctr_width-1];

    a_train_index_known: assert property (
        @(posedge clk) disable iff (!arst_n)
        train_en |-> !$isunknown(train_index)
    ) else $error("pattern table trained at an unknown index");

endmodule

// File: source/choice_table.sv
`timescale 1ns/1ps

module choice_table import bp_pkg::*; (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic [index_width-1:0] read_index,
    input  logic [index_width-1:0] wr_index,
    input  logic                   wr_en,
    input  logic [ctr_width-1:0]   wr_value,
    output logic [ctr_width-1:0]   choice_ctr,
    output logic                   choice_gshare
);

    // chooser counters, low half favours bimodal, high half gshare
    logic [ctr_width-1:0] sel_q [table_depth];

    // control hands over the full next value, so no resolve-side read here
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < table_depth; i++) begin
                sel_q[i] <= ctr_weak_bimodal;
            end
        end else if (wr_en) begin
            sel_q[wr_index] <= wr_value;
        end
    end

    // raw counter travels down the pipe and comes back at ex
    assign choice_ctr = sel_q[read_index];

    // 1 means use gshare
    assign choice_gshare = choice_ctr[ctr_width-1];

endmodule

// File: source/branch_predictor.sv
`timescale 1ns/1ps

module branch_predictor import bp_pkg::*; (
    input  logic [kind_width-1:0] fetch_kind,
    input  logic                  bimodal_taken,
    input  logic                  gshare_taken,
    input  logic                  choice_gshare,
    input  logic                  update_en,
    input  logic [kind_width-1:0] ex_kind,
    input  logic                  ex_taken,
    input  logic                  ex_bimodal_taken,
    input  logic                  ex_gshare_taken,
    input  logic [ctr_width-1:0]  ex_choice_ctr,
    output logic                  taken_pdc,
    output logic                  train_en,
    output logic                  choice_wr_en,
    output logic [ctr_width-1:0]  choice_wr_value,
    output logic                  ghr_shift_en,
    output logic                  ghr_shift_bit
);

    logic gshare_right;
    logic components_differ;

    // final direction per branch kind
    always_comb begin
        case (fetch_kind)
            kind_direct_jump: begin
                taken_pdc = choice_gshare ? gshare_taken : bimodal_taken;
            end
            kind_jump, kind_call, kind_ret, kind_indirect_jump: begin
                taken_pdc = 1'b1;
            end
            kind_not_jump, kind_other_jump: begin
                taken_pdc = 1'b0;
            end
            // code 7 is unused, treat as no branch
            default: begin
                taken_pdc = 1'b0;
            end
        endcase
    end

    // only resolved direct conditionals train anything
    assign train_en = update_en && (ex_kind == kind_direct_jump);

    assign ghr_shift_en  = train_en;
    assign ghr_shift_bit = ex_taken;

    // chooser learns only when the two components disagreed
    assign components_differ = ex_bimodal_taken != ex_gshare_taken;
    assign gshare_right      = ex_gshare_taken == ex_taken;
    assign choice_wr_en      = train_en && components_differ;

    always_comb begin
        choice_wr_value = ex_choice_ctr;
        if (gshare_right) begin
            if (ex_choice_ctr != ctr_max) begin
                choice_wr_value = ex_choice_ctr + 2'd1;
            end
        end else begin
            if (ex_choice_ctr != ctr_min) begin
                choice_wr_value = ex_choice_ctr - 2'd1;
            end
        end
    end

    // no clock in this block, so the kind check runs on every change
    always_comb begin
        if (update_en) begin
            a_ex_kind_defined: assert (ex_kind <= kind_other_jump)
                else $error("resolve strobe with undefined branch kind %0d", ex_kind);
        end
    end

endmodule

// File: source/predictor_top.sv
`timescale 1ns/1ps

module predictor_top import bp_pkg::*; (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic [addr_width-1:0] fetch_pc,
    input  logic [kind_width-1:0] fetch_kind,
    input  logic                  update_en,
    input  logic [addr_width-1:0] ex_pc,
    input  logic [kind_width-1:0] ex_kind,
    input  logic [ghr_width-1:0]  ex_ghr,
    input  logic                  ex_taken,
    input  logic                  ex_bimodal_taken,
    input  logic                  ex_gshare_taken,
    input  logic [ctr_width-1:0]  ex_choice_ctr,
    output logic                  taken_pdc,
    output logic                  choice_gshare,
    output logic [ctr_width-1:0]  choice_ctr,
    output logic                  bimodal_taken,
    output logic                  gshare_taken,
    output logic [ghr_width-1:0]  pred_ghr
);

    logic [index_width-1:0] fetch_bimodal_index;
    logic [index_width-1:0] fetch_gshare_index;
    logic [index_width-1:0] ex_bimodal_index;
    logic [index_width-1:0] ex_gshare_index;
    logic                   train_en;
    logic                   choice_wr_en;
    logic [ctr_width-1:0]   choice_wr_value;
    logic                   ghr_shift_en;
    logic                   ghr_shift_bit;

    index_hash i_index_hash (
        .clk                 (clk),
        .arst_n              (arst_n),
        .fetch_pc            (fetch_pc),
        .ex_pc               (ex_pc),
        .ex_ghr              (ex_ghr),
        .ghr_shift_en        (ghr_shift_en),
        .ghr_shift_bit       (ghr_shift_bit),
        .pred_ghr            (pred_ghr),
        .fetch_bimodal_index (fetch_bimodal_index),
        .fetch_gshare_index  (fetch_gshare_index),
        .ex_bimodal_index    (ex_bimodal_index),
        .ex_gshare_index     (ex_gshare_index)
    );

    // pc only
    pattern_table bimodal_table (
        .clk         (clk),
        .arst_n      (arst_n),
        .read_index  (fetch_bimodal_index),
        .train_index (ex_bimodal_index),
        .train_en    (train_en),
        .train_taken (ex_taken),
        .pred_taken  (bimodal_taken)
    );

    // pc xor history
    pattern_table gshare_table (
        .clk         (clk),
        .arst_n      (arst_n),
        .read_index  (fetch_gshare_index),
        .train_index (ex_gshare_index),
        .train_en    (train_en),
        .train_taken (ex_taken),
        .pred_taken  (gshare_taken)
    );

    // chooser shares the gshare indexing
    choice_table i_choice_table (
        .clk           (clk),
        .arst_n        (arst_n),
        .read_index    (fetch_gshare_index),
        .wr_index      (ex_gshare_index),
        .wr_en         (choice_wr_en),
        .wr_value      (choice_wr_value),
        .choice_ctr    (choice_ctr),
        .choice_gshare (choice_gshare)
    );

    branch_predictor i_branch_predictor (
        .fetch_kind       (fetch_kind),
        .bimodal_taken    (bimodal_taken),
        .gshare_taken     (gshare_taken),
        .choice_gshare    (choice_gshare),
        .update_en        (update_en),
        .ex_kind          (ex_kind),
        .ex_taken         (ex_taken),
        .ex_bimodal_taken (ex_bimodal_taken),
        .ex_gshare_taken  (ex_gshare_taken),
        .ex_choice_ctr    (ex_choice_ctr),
        .taken_pdc        (taken_pdc),
        .train_en         (train_en),
        .choice_wr_en     (choice_wr_en),
        .choice_wr_value  (choice_wr_value),
        .ghr_shift_en     (ghr_shift_en),
        .ghr_shift_bit    (ghr_shift_bit)
    );

endmodule

// File: testbench/tb_tasks.svh
function automatic bit [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
endfunction

task automatic check_value(input string what, input int got, input int expected);
    checks++;
    if (got != expected) begin
        errors++;
        $display("[ERROR] %0t %s: got %0h, expected %0h", $time, what, got, expected);
    end
endtask

task automatic reset_model();
    for (int i = 0; i < table_depth; i++) begin
        m_bim[i] = 2'd1;
        m_gsh[i] = 2'd1;
        m_cho[i] = 2'd1;
    end
    m_ghr = '0;
endtask

function automatic logic [1:0] step_ctr(input logic [1:0] c, input logic up);
    if (up) begin
        return (c == 2'd3) ? c : c + 2'd1;
    end
    return (c == 2'd0) ? c : c - 2'd1;
endfunction

// advance the model by one resolved branch
task automatic model_update(input logic [addr_width-1:0] pc, input logic [2:0] kind,
                            input logic [7:0] ghr, input logic taken, input logic bt,
                            input logic gt, input logic [1:0] cc);
    logic [7:0] gi;
    gi = pc[7:0] ^ ghr;
    if (kind == 3'd1) begin
        m_bim[pc[7:0]] = step_ctr(m_bim[pc[7:0]], taken);
        m_gsh[gi] = step_ctr(m_gsh[gi], taken);
        if (bt != gt) begin
            m_cho[gi] = step_ctr(cc, gt == taken);
        end
        m_ghr = {m_ghr[6:0], taken};
    end
endtask

// compare every fetch output with the model
task automatic compare_outputs(input logic [addr_width-1:0] pc, input logic [2:0] kind);
    logic [7:0] gi;
    logic       exp_taken;
    gi = pc[7:0] ^ m_ghr;
    case (kind)
        3'd1: exp_taken = m_cho[gi][1] ? m_gsh[gi][1] : m_bim[pc[7:0]][1];
        3'd2, 3'd3, 3'd4, 3'd5: exp_taken = 1'b1;
        default: exp_taken = 1'b0;
    endcase
    check_value("taken_pdc", taken_pdc, exp_taken);
    check_value("choice_gshare", choice_gshare, m_cho[gi][1]);
    check_value("choice_ctr", choice_ctr, m_cho[gi]);
    check_value("bimodal_taken", bimodal_taken, m_bim[pc[7:0]][1]);
    check_value("gshare_taken", gshare_taken, m_gsh[gi][1]);
    check_value("pred_ghr", pred_ghr, m_ghr);
endtask

task automatic drive_pending();
    update_en = pend_valid;
    ex_pc = pend_pc;
    ex_kind = pend_kind;
    ex_ghr = pend_ghr;
    ex_taken = pend_taken;
    ex_bimodal_taken = pend_bt;
    ex_gshare_taken = pend_gt;
    ex_choice_ctr = pend_cc;
endtask

// fetch one branch while the previous one resolves, called 0.5 ns after an edge
task automatic issue_branch(input logic [addr_width-1:0] pc, input logic [2:0] kind,
                            input logic taken);
    logic [ghr_width-1:0] seen_ghr;
    logic                 seen_bt;
    logic                 seen_gt;
    logic [ctr_width-1:0] seen_cc;
    fetch_pc = pc;
    fetch_kind = kind;
    drive_pending();
    #1;
    compare_outputs(pc, kind);
    // what the core carries down the pipe from this fetch
    seen_ghr = pred_ghr;
    seen_bt = bimodal_taken;
    seen_gt = gshare_taken;
    seen_cc = choice_ctr;
    @(posedge clk);
    #0.5;
    if (pend_valid) begin
        model_update(pend_pc, pend_kind, pend_ghr, pend_taken, pend_bt, pend_gt, pend_cc);
    end
    pend_valid = 1'b1;
    pend_pc = pc;
    pend_kind = kind;
    pend_ghr = seen_ghr;
    pend_taken = taken;
    pend_bt = seen_bt;
    pend_gt = seen_gt;
    pend_cc = seen_cc;
    issued++;
endtask

// resolve the last branch with no new fetch behind it
task automatic flush_update();
    fetch_kind = kind_not_jump;
    drive_pending();
    @(posedge clk);
    #0.5;
    if (pend_valid) begin
        model_update(pend_pc, pend_kind, pend_ghr, pend_taken, pend_bt, pend_gt, pend_cc);
    end
    pend_valid = 1'b0;
    update_en = 1'b0;
endtask

task automatic check_fetch(input logic [addr_width-1:0] pc, input logic [2:0] kind);
    fetch_pc = pc;
    fetch_kind = kind;
    update_en = 1'b0;
    #1;
    compare_outputs(pc, kind);
    @(posedge clk);
    #0.5;
endtask

task automatic test_reset_state();
    bit [31:0]             r;
    logic [addr_width-1:0] pc;
    for (int i = 0; i < 8; i++) begin
        r = next_rand();
        pc = r[addr_width-1:0];
        fetch_pc = pc;
        fetch_kind = kind_direct_jump;
        #1;
        check_value("reset taken_pdc", taken_pdc, 0);
        check_value("reset choice_ctr", choice_ctr, 1);
        check_value("reset bimodal_taken", bimodal_taken, 0);
        check_value("reset gshare_taken", gshare_taken, 0);
        check_value("reset pred_ghr", pred_ghr, 0);
        @(posedge clk);
        #0.5;
    end
endtask

task automatic test_kind_decode();
    logic [7:0] ghr_before;
    // make pc 0x40 strongly taken first
    for (int i = 0; i < 4; i++) begin
        issue_branch(30'h40, kind_direct_jump, 1'b1);
        flush_update();
    end
    for (int k = 0; k < 8; k++) begin
        fetch_pc = 30'h40;
        fetch_kind = k[2:0];
        #1;
        // conditional branches follow the tables, checked against the model below
        if (k != 1) begin
            check_value("kind decode", taken_pdc, (k >= 2 && k <= 5));
        end
        @(posedge clk);
        #0.5;
        check_fetch(30'h40, k[2:0]);
    end
    // resolves of other kinds leave the history alone
    ghr_before = m_ghr;
    for (int k = 2; k <= 6; k++) begin
        issue_branch(30'h40, k[2:0], 1'b1);
        flush_update();
        check_value("ghr after non-conditional", pred_ghr, ghr_before);
    end
    issue_branch(30'h40, kind_not_jump, 1'b1);
    flush_update();
    check_value("ghr after not-jump", pred_ghr, ghr_before);
endtask

task automatic test_bimodal_training();
    logic [addr_width-1:0] pc;
    pc = 30'h2b7;
    // three taken, then two not taken
    for (int i = 0; i < 5; i++) begin
        issue_branch(pc, kind_direct_jump, i < 3);
        flush_update();
        fetch_pc = pc;
        fetch_kind = kind_direct_jump;
        #1;
        check_value("bimodal counter direction", bimodal_taken, (i < 4) ? 1 : 0);
        @(posedge clk);
        #0.5;
    end
endtask

task automatic test_history_gshare();
    for (int i = 0; i < 40; i++) begin
        issue_branch(30'h15c, kind_direct_jump, i[0]);
        flush_update();
    end
endtask

// strobe a resolve with chosen component predictions and chooser counter
task automatic forced_chooser(input logic bt, input logic gt, input logic taken,
                              input logic [1:0] cc, input int expected);
    logic [7:0] old_ghr;
    old_ghr = m_ghr;
    pend_valid = 1'b1;
    pend_pc = 30'h0a5;
    pend_kind = kind_direct_jump;
    pend_ghr = old_ghr;
    pend_taken = taken;
    pend_bt = bt;
    pend_gt = gt;
    pend_cc = cc;
    flush_update();
    // refetch the same gshare entry under the shifted history
    fetch_pc = 30'h0a5 ^ {22'd0, old_ghr ^ m_ghr};
    fetch_kind = kind_direct_jump;
    #1;
    check_value("chooser value", choice_ctr, expected);
    check_value("chooser select", choice_gshare, expected >= 2);
    @(posedge clk);
    #0.5;
    check_fetch(30'h0a5 ^ {22'd0, old_ghr ^ m_ghr}, kind_direct_jump);
endtask

task automatic test_chooser();
    forced_chooser(1'b0, 1'b1, 1'b1, 2'd2, 3);
    forced_chooser(1'b0, 1'b1, 1'b1, 2'd3, 3);
    forced_chooser(1'b1, 1'b0, 1'b1, 2'd1, 0);
    forced_chooser(1'b0, 1'b1, 1'b0, 2'd0, 0);
    // agreeing components leave the stored entry as it was
    forced_chooser(1'b1, 1'b1, 1'b0, 2'd3, m_cho[8'ha5 ^ m_ghr]);
endtask

task automatic test_random_stream();
    bit [31:0]  r;
    logic [2:0] kind;
    for (int i = 0; i < 300; i++) begin
        r = next_rand();
        kind = (r[2:0] < 3'd4) ? kind_direct_jump : r[5:3] % 3'd7;
        // a small pc pool so entries collide
        issue_branch({22'd0, r[15:13], r[10:6]}, kind, r[20] ^ r[21]);
    end
    flush_update();
endtask

// File: testbench/tb_predictor_top.sv
`timescale 1ns/1ps

module tb_predictor_top import bp_pkg::*; ();

    localparam time clk_period = 4ns;
    // decode, bimodal, history, chooser and random stream branches
    localparam int planned_branches = 10 + 5 + 40 + 5 + 300;
    localparam int reset_cycles = 10;

    logic                  clk;
    logic                  arst_n;
    logic [addr_width-1:0] fetch_pc;
    logic [kind_width-1:0] fetch_kind;
    logic                  update_en;
    logic [addr_width-1:0] ex_pc;
    logic [kind_width-1:0] ex_kind;
    logic [ghr_width-1:0]  ex_ghr;
    logic                  ex_taken;
    logic                  ex_bimodal_taken;
    logic                  ex_gshare_taken;
    logic [ctr_width-1:0]  ex_choice_ctr;
    logic                  taken_pdc;
    logic                  choice_gshare;
    logic [ctr_width-1:0]  choice_ctr;
    logic                  bimodal_taken;
    logic                  gshare_taken;
    logic [ghr_width-1:0]  pred_ghr;

    // reference model state
    logic [ctr_width-1:0] m_bim [table_depth];
    logic [ctr_width-1:0] m_gsh [table_depth];
    logic [ctr_width-1:0] m_cho [table_depth];
    logic [ghr_width-1:0] m_ghr;

    // branch waiting for its resolve strobe
    logic                  pend_valid;
    logic [addr_width-1:0] pend_pc;
    logic [kind_width-1:0] pend_kind;
    logic [ghr_width-1:0]  pend_ghr;
    logic                  pend_taken;
    logic                  pend_bt;
    logic                  pend_gt;
    logic [ctr_width-1:0]  pend_cc;

    int        checks;
    int        errors;
    int        issued;
    bit [31:0] seed;

    `include "tb_tasks.svh"

    predictor_top i_predictor_top (
        .clk              (clk),
        .arst_n           (arst_n),
        .fetch_pc         (fetch_pc),
        .fetch_kind       (fetch_kind),
        .update_en        (update_en),
        .ex_pc            (ex_pc),
        .ex_kind          (ex_kind),
        .ex_ghr           (ex_ghr),
        .ex_taken         (ex_taken),
        .ex_bimodal_taken (ex_bimodal_taken),
        .ex_gshare_taken  (ex_gshare_taken),
        .ex_choice_ctr    (ex_choice_ctr),
        .taken_pdc        (taken_pdc),
        .choice_gshare    (choice_gshare),
        .choice_ctr       (choice_ctr),
        .bimodal_taken    (bimodal_taken),
        .gshare_taken     (gshare_taken),
        .pred_ghr         (pred_ghr)
    );

    always #(clk_period / 2) clk = ~clk;

    initial begin
        #((planned_branches * 3 + reset_cycles) * clk_period);
        $display("timeout: the tests did not finish in time, %0d branches issued", issued);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        clk = 1'b0;
        arst_n = 1'b0;
        fetch_pc = '0;
        fetch_kind = kind_not_jump;
        update_en = 1'b0;
        ex_pc = '0;
        ex_kind = kind_not_jump;
        ex_ghr = '0;
        ex_taken = 1'b0;
        ex_bimodal_taken = 1'b0;
        ex_gshare_taken = 1'b0;
        ex_choice_ctr = '0;
        pend_valid = 1'b0;
        checks = 0;
        errors = 0;
        issued = 0;
        seed = 32'hf17e2a27;
        reset_model();
        repeat (reset_cycles) @(posedge clk);
        #0.5;
        arst_n = 1'b1;
        test_reset_state();
        test_kind_decode();
        test_bimodal_training();
        test_history_gshare();
        test_chooser();
        test_random_stream();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: verilog.f
+incdir+testbench
source/bp_pkg.sv
source/index_hash.sv
source/pattern_table.sv
source/choice_table.sv
source/branch_predictor.sv
source/predictor_top.sv
testbench/tb_predictor_top.sv

// File: run_sim.sh
#!/bin/sh
# build and run the predictor testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_predictor_top -f verilog.f -o tb_sim \
    > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/tb_sim > sim.log 2>&1
cat sim.log

grep -q "STATUS: FAIL" sim.log && exit 1 || grep -q "STATUS: PASS" sim.log || exit 1
exit 0
